// File: source/decode_pkg.sv
package decode_pkg;

	localparam int word_w = 16;
	localparam int reg_w = 4;

	typedef logic [word_w-1:0] word_t;
	typedef logic [reg_w-1:0] reg_addr_t;

	// Special registers above the eight general ones
	localparam reg_addr_t reg_sp = 4'd8;
	localparam reg_addr_t reg_t = 4'd9;
	localparam reg_addr_t reg_ra = 4'd11;
	localparam reg_addr_t reg_none = 4'd15;

	////////////////////////////////////////////////////////////////////////////
	// Major opcodes, bits 15:11
	////////////////////////////////////////////////////////////////////////////

	localparam logic [4:0] op_nop = 5'b00001;
	localparam logic [4:0] op_b = 5'b00010;
	localparam logic [4:0] op_beqz = 5'b00100;
	localparam logic [4:0] op_bnez = 5'b00101;
	localparam logic [4:0] op_shift = 5'b00110;
	localparam logic [4:0] op_addiu3 = 5'b01000;
	localparam logic [4:0] op_addiu = 5'b01001;
	localparam logic [4:0] op_group_sp = 5'b01100;
	localparam logic [4:0] op_li = 5'b01101;
	localparam logic [4:0] op_cmpi = 5'b01110;
	localparam logic [4:0] op_lw_sp = 5'b10010;
	localparam logic [4:0] op_lw = 5'b10011;
	localparam logic [4:0] op_sw_sp = 5'b11010;
	localparam logic [4:0] op_sw = 5'b11011;
	localparam logic [4:0] op_addsubu = 5'b11100;
	localparam logic [4:0] op_group_rr = 5'b11101;

	// SP group, bits 10:8
	localparam logic [2:0] sp_bteqz = 3'b000;
	localparam logic [2:0] sp_btnez = 3'b001;
	localparam logic [2:0] sp_sw_rs = 3'b010;
	localparam logic [2:0] sp_addsp = 3'b011;
	localparam logic [2:0] sp_mtsp = 3'b100;

	// ADDU/SUBU and shifts, bits 1:0
	localparam logic [1:0] fn_addu = 2'b01;
	localparam logic [1:0] fn_subu = 2'b11;
	localparam logic [1:0] fn_sll = 2'b00;
	localparam logic [1:0] fn_sra = 2'b11;

	// Register group, bits 4:0
	localparam logic [4:0] rr_pc = 5'b00000;
	localparam logic [4:0] rr_slt = 5'b00010;
	localparam logic [4:0] rr_srav = 5'b00111;
	localparam logic [4:0] rr_cmp = 5'b01010;
	localparam logic [4:0] rr_and = 5'b01100;
	localparam logic [4:0] rr_or = 5'b01101;

	// JR/MFPC, bits 7:5
	localparam logic [2:0] pc_jr = 3'b000;
	localparam logic [2:0] pc_mfpc = 3'b010;

	////////////////////////////////////////////////////////////////////////////
	// Decoded types
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [4:0] {
		kind_nop, kind_addiu, kind_addiu3, kind_addsp, kind_bteqz,
		kind_btnez, kind_mtsp, kind_sw_rs, kind_addu, kind_subu,
		kind_b, kind_beqz, kind_bnez, kind_and, kind_or,
		kind_cmp, kind_slt, kind_srav, kind_jr, kind_mfpc,
		kind_li, kind_lw, kind_lw_sp, kind_sll, kind_sra,
		kind_sw, kind_sw_sp, kind_cmpi
	} instr_kind_e;

	typedef enum logic [3:0] {
		alu_add = 4'd0,
		alu_and = 4'd1,
		alu_or = 4'd2,
		alu_sll = 4'd3,
		alu_srl = 4'd4,
		alu_sra = 4'd5,
		alu_sub = 4'd6,
		alu_equal = 4'd7,
		alu_less = 4'd8,
		alu_move = 4'd9,
		alu_empty = 4'd15
	} alu_op_e;

	typedef enum logic [2:0] {
		src_none = 3'd0,
		r1_r2 = 3'd1,
		r1_im = 3'd2,
		r1_nu = 3'd3, // Register passed through
		im_nu = 3'd4 // Immediate passed through
	} alu_src_e;

	typedef enum logic [1:0] {
		br_always = 2'd0,
		br_eqz = 2'd1,
		br_nez = 2'd2,
		br_none = 2'd3
	} branch_cond_e;

endpackage

// File: source/ctrl_if.sv
`timescale 1ns/1ps

interface ctrl_if;

	decode_pkg::alu_op_e alu_op;
	decode_pkg::alu_src_e alu_src;
	decode_pkg::branch_cond_e branch_cond;
	logic is_jump;
	logic mem_read;
	logic mem_write;
	logic reg_write;
	logic mem_to_reg; // Write-back from memory, not ALU

	modport source(
		output alu_op, alu_src, branch_cond, is_jump,
		output mem_read, mem_write, reg_write, mem_to_reg
	);

	modport sink(
		input alu_op, alu_src, branch_cond, is_jump,
		input mem_read, mem_write, reg_write, mem_to_reg
	);

endinterface

// File: source/operand_if.sv
`timescale 1ns/1ps

interface operand_if;

	// Register file read ports
	decode_pkg::reg_addr_t reg_a;
	decode_pkg::reg_addr_t reg_b;

	// Hazard sources
	decode_pkg::reg_addr_t src_a;
	decode_pkg::reg_addr_t src_b;
	decode_pkg::reg_addr_t src_sw; // Store data register

	decode_pkg::reg_addr_t w_reg;
	decode_pkg::word_t immediate;

	modport source(
		output reg_a, reg_b, src_a, src_b, src_sw,
		output w_reg, immediate
	);

	modport sink(
		input reg_a, reg_b, src_a, src_b, src_sw,
		input w_reg, immediate
	);

endinterface

// File: source/instr_classify.sv
`timescale 1ns/1ps

module instr_classify (
	input decode_pkg::word_t instruction,
	output decode_pkg::instr_kind_e kind
);

	logic [4:0] op;

	assign op = instruction[15:11];

	always_comb begin
		kind = decode_pkg::kind_nop;
		case (op)
			decode_pkg::op_nop: kind = decode_pkg::kind_nop;
			decode_pkg::op_b: kind = decode_pkg::kind_b;
			decode_pkg::op_beqz: kind = decode_pkg::kind_beqz;
			decode_pkg::op_bnez: kind = decode_pkg::kind_bnez;
			decode_pkg::op_addiu3: kind = decode_pkg::kind_addiu3;
			decode_pkg::op_addiu: kind = decode_pkg::kind_addiu;
			decode_pkg::op_li: kind = decode_pkg::kind_li;
			decode_pkg::op_cmpi: kind = decode_pkg::kind_cmpi;
			decode_pkg::op_lw_sp: kind = decode_pkg::kind_lw_sp;
			decode_pkg::op_lw: kind = decode_pkg::kind_lw;
			decode_pkg::op_sw_sp: kind = decode_pkg::kind_sw_sp;
			decode_pkg::op_sw: kind = decode_pkg::kind_sw;
			decode_pkg::op_shift: begin
				case (instruction[1:0])
					decode_pkg::fn_sll: kind = decode_pkg::kind_sll;
					decode_pkg::fn_sra: kind = decode_pkg::kind_sra;
					default: kind = decode_pkg::kind_nop;
				endcase
			end
			decode_pkg::op_addsubu: begin
				case (instruction[1:0])
					decode_pkg::fn_addu: kind = decode_pkg::kind_addu;
					decode_pkg::fn_subu: kind = decode_pkg::kind_subu;
					default: kind = decode_pkg::kind_nop;
				endcase
			end
			decode_pkg::op_group_sp: begin
				case (instruction[10:8])
					decode_pkg::sp_bteqz: kind = decode_pkg::kind_bteqz;
					decode_pkg::sp_btnez: kind = decode_pkg::kind_btnez;
					decode_pkg::sp_sw_rs: kind = decode_pkg::kind_sw_rs;
					decode_pkg::sp_addsp: kind = decode_pkg::kind_addsp;
					decode_pkg::sp_mtsp: kind = decode_pkg::kind_mtsp;
					default: kind = decode_pkg::kind_nop;
				endcase
			end
			decode_pkg::op_group_rr: begin
				case (instruction[4:0])
					decode_pkg::rr_and: kind = decode_pkg::kind_and;
					decode_pkg::rr_or: kind = decode_pkg::kind_or;
					decode_pkg::rr_cmp: kind = decode_pkg::kind_cmp;
					decode_pkg::rr_slt: kind = decode_pkg::kind_slt;
					decode_pkg::rr_srav: kind = decode_pkg::kind_srav;
					decode_pkg::rr_pc: begin // JR and MFPC share this code
						case (instruction[7:5])
							decode_pkg::pc_jr: kind = decode_pkg::kind_jr;
							decode_pkg::pc_mfpc: kind = decode_pkg::kind_mfpc;
							default: kind = decode_pkg::kind_nop;
						endcase
					end
					default: kind = decode_pkg::kind_nop;
				endcase
			end
			default: kind = decode_pkg::kind_nop; // Interrupt group lands here too
		endcase
	end

endmodule

// File: source/control_gen.sv
`timescale 1ns/1ps

module control_gen (
	input decode_pkg::instr_kind_e kind,
	ctrl_if.source ctrl
);

	////////////////////////////////////////////////////////////////////////////
	// ALU operation and operand selection
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		ctrl.alu_op = decode_pkg::alu_empty;
		ctrl.alu_src = decode_pkg::src_none;
		case (kind)
			decode_pkg::kind_addiu, decode_pkg::kind_addiu3, decode_pkg::kind_addsp,
			decode_pkg::kind_lw, decode_pkg::kind_lw_sp, decode_pkg::kind_sw,
			decode_pkg::kind_sw_sp, decode_pkg::kind_sw_rs: begin
				ctrl.alu_op = decode_pkg::alu_add; // Also address generation
				ctrl.alu_src = decode_pkg::r1_im;
			end
			decode_pkg::kind_addu: begin
				ctrl.alu_op = decode_pkg::alu_add;
				ctrl.alu_src = decode_pkg::r1_r2;
			end
			decode_pkg::kind_subu: begin
				ctrl.alu_op = decode_pkg::alu_sub;
				ctrl.alu_src = decode_pkg::r1_r2;
			end
			decode_pkg::kind_and: begin
				ctrl.alu_op = decode_pkg::alu_and;
				ctrl.alu_src = decode_pkg::r1_r2;
			end
			decode_pkg::kind_or: begin
				ctrl.alu_op = decode_pkg::alu_or;
				ctrl.alu_src = decode_pkg::r1_r2;
			end
			decode_pkg::kind_cmp: begin
				ctrl.alu_op = decode_pkg::alu_equal;
				ctrl.alu_src = decode_pkg::r1_r2;
			end
			decode_pkg::kind_slt: begin
				ctrl.alu_op = decode_pkg::alu_less;
				ctrl.alu_src = decode_pkg::r1_r2;
			end
			decode_pkg::kind_srav: begin
				ctrl.alu_op = decode_pkg::alu_sra;
				ctrl.alu_src = decode_pkg::r1_r2;
			end
			decode_pkg::kind_sll: begin
				ctrl.alu_op = decode_pkg::alu_sll;
				ctrl.alu_src = decode_pkg::r1_im;
			end
			decode_pkg::kind_sra: begin
				ctrl.alu_op = decode_pkg::alu_sra;
				ctrl.alu_src = decode_pkg::r1_im;
			end
			decode_pkg::kind_cmpi: begin
				ctrl.alu_op = decode_pkg::alu_equal;
				ctrl.alu_src = decode_pkg::r1_im;
			end
			decode_pkg::kind_mtsp: begin
				ctrl.alu_op = decode_pkg::alu_move;
				ctrl.alu_src = decode_pkg::r1_nu;
			end
			decode_pkg::kind_li, decode_pkg::kind_mfpc: begin
				ctrl.alu_op = decode_pkg::alu_move;
				ctrl.alu_src = decode_pkg::im_nu;
			end
			default: ; // Branches, JR and NOP keep the idle ALU
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Flow, memory and write-back
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (kind)
			decode_pkg::kind_b: ctrl.branch_cond = decode_pkg::br_always;
			decode_pkg::kind_beqz,
			decode_pkg::kind_bteqz: ctrl.branch_cond = decode_pkg::br_eqz;
			decode_pkg::kind_bnez,
			decode_pkg::kind_btnez: ctrl.branch_cond = decode_pkg::br_nez;
			default: ctrl.branch_cond = decode_pkg::br_none;
		endcase
	end

	assign ctrl.is_jump = (kind == decode_pkg::kind_jr);

	assign ctrl.mem_read = (kind == decode_pkg::kind_lw) || (kind == decode_pkg::kind_lw_sp);
	assign ctrl.mem_to_reg = ctrl.mem_read;
	assign ctrl.mem_write = (kind == decode_pkg::kind_sw) || (kind == decode_pkg::kind_sw_sp) ||
		(kind == decode_pkg::kind_sw_rs);

	always_comb begin
		case (kind)
			decode_pkg::kind_addiu, decode_pkg::kind_addiu3, decode_pkg::kind_addsp,
			decode_pkg::kind_mtsp, decode_pkg::kind_addu, decode_pkg::kind_subu,
			decode_pkg::kind_and, decode_pkg::kind_or, decode_pkg::kind_cmp,
			decode_pkg::kind_slt, decode_pkg::kind_srav, decode_pkg::kind_mfpc,
			decode_pkg::kind_li, decode_pkg::kind_lw, decode_pkg::kind_lw_sp,
			decode_pkg::kind_sll, decode_pkg::kind_sra,
			decode_pkg::kind_cmpi: ctrl.reg_write = 1'b1;
			default: ctrl.reg_write = 1'b0;
		endcase
	end

endmodule

// File: source/operand_gen.sv
`timescale 1ns/1ps

module operand_gen (
	input decode_pkg::instr_kind_e kind,
	input decode_pkg::word_t instruction,
	input decode_pkg::word_t pc,
	operand_if.source opnd
);

	decode_pkg::reg_addr_t rx;
	decode_pkg::reg_addr_t ry;
	decode_pkg::reg_addr_t rz;
	decode_pkg::reg_addr_t reg_a_sel;
	decode_pkg::reg_addr_t reg_b_sel;
	decode_pkg::word_t shamt;
	logic flow_change; // Branch or JR
	logic two_reg;

	assign rx = {1'b0, instruction[10:8]};
	assign ry = {1'b0, instruction[7:5]};
	assign rz = {1'b0, instruction[4:2]};

	// Shift field of 0 encodes a shift by 8
	assign shamt = (instruction[4:2] == 3'd0) ? decode_pkg::word_t'(8) :
		decode_pkg::word_t'(instruction[4:2]);

	assign flow_change = (kind == decode_pkg::kind_b) || (kind == decode_pkg::kind_beqz) ||
		(kind == decode_pkg::kind_bnez) || (kind == decode_pkg::kind_bteqz) ||
		(kind == decode_pkg::kind_btnez) || (kind == decode_pkg::kind_jr);

	assign two_reg = (kind == decode_pkg::kind_addu) || (kind == decode_pkg::kind_subu) ||
		(kind == decode_pkg::kind_and) || (kind == decode_pkg::kind_or) ||
		(kind == decode_pkg::kind_cmp) || (kind == decode_pkg::kind_slt) ||
		(kind == decode_pkg::kind_srav);

	////////////////////////////////////////////////////////////////////////////
	// Register reads and hazard sources
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (kind)
			decode_pkg::kind_mtsp, decode_pkg::kind_sll, decode_pkg::kind_sra,
			decode_pkg::kind_srav: reg_a_sel = ry;
			decode_pkg::kind_addsp, decode_pkg::kind_lw_sp, decode_pkg::kind_sw_sp,
			decode_pkg::kind_sw_rs: reg_a_sel = decode_pkg::reg_sp;
			decode_pkg::kind_bteqz, decode_pkg::kind_btnez: reg_a_sel = decode_pkg::reg_t;
			decode_pkg::kind_b, decode_pkg::kind_li, decode_pkg::kind_mfpc,
			decode_pkg::kind_nop: reg_a_sel = decode_pkg::reg_none;
			default: reg_a_sel = rx;
		endcase
	end

	always_comb begin
		case (kind)
			decode_pkg::kind_addu, decode_pkg::kind_subu, decode_pkg::kind_and,
			decode_pkg::kind_or, decode_pkg::kind_cmp, decode_pkg::kind_slt,
			decode_pkg::kind_sw: reg_b_sel = ry;
			decode_pkg::kind_srav, decode_pkg::kind_sw_sp: reg_b_sel = rx;
			decode_pkg::kind_sw_rs: reg_b_sel = decode_pkg::reg_ra;
			default: reg_b_sel = decode_pkg::reg_none;
		endcase
	end

	assign opnd.reg_a = reg_a_sel;
	assign opnd.reg_b = reg_b_sel;
	assign opnd.src_a = flow_change ? decode_pkg::reg_none : reg_a_sel;
	assign opnd.src_b = two_reg ? reg_b_sel : decode_pkg::reg_none;

	// Store data read through port B for every store
	assign opnd.src_sw = ctrl_store(kind) ? reg_b_sel : decode_pkg::reg_none;

	function automatic logic ctrl_store(input decode_pkg::instr_kind_e k);
		return (k == decode_pkg::kind_sw) || (k == decode_pkg::kind_sw_sp) ||
			(k == decode_pkg::kind_sw_rs);
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Write register and immediate
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (kind)
			decode_pkg::kind_addiu, decode_pkg::kind_and, decode_pkg::kind_or,
			decode_pkg::kind_mfpc, decode_pkg::kind_li, decode_pkg::kind_lw_sp,
			decode_pkg::kind_sll, decode_pkg::kind_sra: opnd.w_reg = rx;
			decode_pkg::kind_addiu3, decode_pkg::kind_lw,
			decode_pkg::kind_srav: opnd.w_reg = ry;
			decode_pkg::kind_addu, decode_pkg::kind_subu: opnd.w_reg = rz;
			decode_pkg::kind_addsp, decode_pkg::kind_mtsp: opnd.w_reg = decode_pkg::reg_sp;
			decode_pkg::kind_cmp, decode_pkg::kind_slt,
			decode_pkg::kind_cmpi: opnd.w_reg = decode_pkg::reg_t;
			default: opnd.w_reg = decode_pkg::reg_none;
		endcase
	end

	always_comb begin
		case (kind)
			decode_pkg::kind_addiu, decode_pkg::kind_addsp, decode_pkg::kind_beqz,
			decode_pkg::kind_bnez, decode_pkg::kind_bteqz, decode_pkg::kind_btnez,
			decode_pkg::kind_lw_sp, decode_pkg::kind_sw_sp, decode_pkg::kind_sw_rs,
			decode_pkg::kind_cmpi:
				opnd.immediate = {{(decode_pkg::word_w - 8){instruction[7]}}, instruction[7:0]};
			decode_pkg::kind_addiu3:
				opnd.immediate = {{(decode_pkg::word_w - 4){instruction[3]}}, instruction[3:0]};
			decode_pkg::kind_lw, decode_pkg::kind_sw:
				opnd.immediate = {{(decode_pkg::word_w - 5){instruction[4]}}, instruction[4:0]};
			decode_pkg::kind_b:
				opnd.immediate = {{(decode_pkg::word_w - 11){instruction[10]}}, instruction[10:0]};
			decode_pkg::kind_li:
				opnd.immediate = {{(decode_pkg::word_w - 8){1'b0}}, instruction[7:0]};
			decode_pkg::kind_mfpc: opnd.immediate = pc;
			decode_pkg::kind_sll, decode_pkg::kind_sra: opnd.immediate = shamt;
			default: opnd.immediate = '0;
		endcase
	end

endmodule

// File: source/id_register.sv
`timescale 1ns/1ps

module id_register (
	input logic clk,
	input logic rst,
	ctrl_if.sink ctrl,
	operand_if.sink opnd,
	output decode_pkg::alu_op_e alu_op,
	output decode_pkg::alu_src_e alu_src,
	output decode_pkg::branch_cond_e branch_cond,
	output logic is_jump,
	output logic mem_read,
	output logic mem_write,
	output logic reg_write,
	output logic mem_to_reg,
	output decode_pkg::reg_addr_t reg_a,
	output decode_pkg::reg_addr_t reg_b,
	output decode_pkg::reg_addr_t src_a,
	output decode_pkg::reg_addr_t src_b,
	output decode_pkg::reg_addr_t src_sw,
	output decode_pkg::reg_addr_t w_reg,
	output decode_pkg::word_t immediate
);

	always_ff @(posedge clk) begin
		if (rst) begin // Load the NOP word
			alu_op <= decode_pkg::alu_empty;
			alu_src <= decode_pkg::src_none;
			branch_cond <= decode_pkg::br_none;
			is_jump <= 1'b0;
			mem_read <= 1'b0;
			mem_write <= 1'b0;
			reg_write <= 1'b0;
			mem_to_reg <= 1'b0;
			reg_a <= decode_pkg::reg_none;
			reg_b <= decode_pkg::reg_none;
			src_a <= decode_pkg::reg_none;
			src_b <= decode_pkg::reg_none;
			src_sw <= decode_pkg::reg_none;
			w_reg <= decode_pkg::reg_none;
			immediate <= '0;
		end else begin
			alu_op <= ctrl.alu_op;
			alu_src <= ctrl.alu_src;
			branch_cond <= ctrl.branch_cond;
			is_jump <= ctrl.is_jump;
			mem_read <= ctrl.mem_read;
			mem_write <= ctrl.mem_write;
			reg_write <= ctrl.reg_write;
			mem_to_reg <= ctrl.mem_to_reg;
			reg_a <= opnd.reg_a;
			reg_b <= opnd.reg_b;
			src_a <= opnd.src_a;
			src_b <= opnd.src_b;
			src_sw <= opnd.src_sw;
			w_reg <= opnd.w_reg;
			immediate <= opnd.immediate;
		end
	end

endmodule

// File: source/decoder_top.sv
`timescale 1ns/1ps

module decoder_top (
	input logic clk,
	input logic rst,
	input decode_pkg::word_t instruction,
	input decode_pkg::word_t pc,
	output decode_pkg::alu_op_e alu_op,
	output decode_pkg::alu_src_e alu_src,
	output decode_pkg::branch_cond_e branch_cond,
	output logic is_jump,
	output logic mem_read,
	output logic mem_write,
	output logic reg_write,
	output logic mem_to_reg,
	output decode_pkg::reg_addr_t reg_a,
	output decode_pkg::reg_addr_t reg_b,
	output decode_pkg::reg_addr_t src_a,
	output decode_pkg::reg_addr_t src_b,
	output decode_pkg::reg_addr_t src_sw,
	output decode_pkg::reg_addr_t w_reg,
	output decode_pkg::word_t immediate
);

	decode_pkg::instr_kind_e kind;

	ctrl_if ctrl_bus ();
	operand_if opnd_bus ();

	instr_classify u_classify (.instruction(instruction), .kind(kind));

	control_gen u_control (.kind(kind), .ctrl(ctrl_bus.source));

	operand_gen u_operand (
		.kind(kind),
		.instruction(instruction),
		.pc(pc),
		.opnd(opnd_bus.source)
	);

	id_register u_id_ex (
		.clk(clk),
		.rst(rst),
		.ctrl(ctrl_bus.sink),
		.opnd(opnd_bus.sink),
		.alu_op(alu_op),
		.alu_src(alu_src),
		.branch_cond(branch_cond),
		.is_jump(is_jump),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.reg_write(reg_write),
		.mem_to_reg(mem_to_reg),
		.reg_a(reg_a),
		.reg_b(reg_b),
		.src_a(src_a),
		.src_b(src_b),
		.src_sw(src_sw),
		.w_reg(w_reg),
		.immediate(immediate)
	);

endmodule

// File: test/decoder_assertions.sv
`timescale 1ns/1ps

module decoder_assertions (
	input logic clk,
	input logic rst,
	input decode_pkg::branch_cond_e branch_cond,
	input logic is_jump,
	input logic mem_read,
	input logic mem_write,
	input logic reg_write,
	input logic mem_to_reg
);

	int failures = 0; // Read by the testbench

	assert property (@(posedge clk) disable iff (rst) !(mem_read && mem_write))
		else begin
			$error("mem_read and mem_write both set");
			failures++;
		end

	assert property (@(posedge clk) disable iff (rst) mem_to_reg |-> reg_write)
		else begin
			$error("mem_to_reg without reg_write");
			failures++;
		end

	assert property (@(posedge clk) disable iff (rst)
		(branch_cond != decode_pkg::br_none) |-> (!is_jump && !reg_write))
		else begin
			$error("Branch also jumps or writes back");
			failures++;
		end

	// Reset loads the NOP word on the same edge
	assert property (@(posedge clk) rst |=> (!is_jump && !mem_read && !mem_write &&
		!reg_write && !mem_to_reg && branch_cond == decode_pkg::br_none))
		else begin
			$error("Control outputs active after a reset cycle");
			failures++;
		end

endmodule

bind decoder_top decoder_assertions u_assert (
	.clk(clk),
	.rst(rst),
	.branch_cond(branch_cond),
	.is_jump(is_jump),
	.mem_read(mem_read),
	.mem_write(mem_write),
	.reg_write(reg_write),
	.mem_to_reg(mem_to_reg)
);

// File: test/decode_model.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// One expected ID/EX word, field for field as the DUT drives it
typedef struct packed {
	decode_pkg::alu_op_e alu_op;
	decode_pkg::alu_src_e alu_src;
	decode_pkg::branch_cond_e branch_cond;
	logic is_jump;
	logic mem_read;
	logic mem_write;
	logic reg_write;
	logic mem_to_reg;
	decode_pkg::reg_addr_t reg_a;
	decode_pkg::reg_addr_t reg_b;
	decode_pkg::reg_addr_t src_a;
	decode_pkg::reg_addr_t src_b;
	decode_pkg::reg_addr_t src_sw;
	decode_pkg::reg_addr_t w_reg;
	decode_pkg::word_t immediate;
} id_word_t;

// Flow and memory fields start idle
function automatic id_word_t entry(input decode_pkg::alu_op_e op,
	input decode_pkg::alu_src_e src, input decode_pkg::reg_addr_t a,
	input decode_pkg::reg_addr_t b, input decode_pkg::reg_addr_t w,
	input decode_pkg::word_t imm);
	id_word_t e;
	e.alu_op = op;
	e.alu_src = src;
	e.branch_cond = decode_pkg::br_none;
	e.is_jump = 1'b0;
	e.mem_read = 1'b0;
	e.mem_write = 1'b0;
	e.reg_write = (w != decode_pkg::reg_none);
	e.mem_to_reg = 1'b0;
	e.reg_a = a;
	e.reg_b = b;
	e.src_a = a;
	e.src_b = decode_pkg::reg_none;
	e.src_sw = decode_pkg::reg_none;
	e.w_reg = w;
	e.immediate = imm;
	return e;
endfunction

function automatic id_word_t nop_word();
	return entry(decode_pkg::alu_empty, decode_pkg::src_none, decode_pkg::reg_none,
		decode_pkg::reg_none, decode_pkg::reg_none, '0);
endfunction

function automatic id_word_t branch_word(input decode_pkg::branch_cond_e cond,
	input decode_pkg::reg_addr_t a, input decode_pkg::word_t imm);
	id_word_t e;
	e = entry(decode_pkg::alu_empty, decode_pkg::src_none, a, decode_pkg::reg_none,
		decode_pkg::reg_none, imm);
	e.branch_cond = cond;
	e.src_a = decode_pkg::reg_none; // Resolved in ID, no EX hazard
	return e;
endfunction

// Address is always base plus offset
function automatic id_word_t mem_word(input logic load, input decode_pkg::reg_addr_t a,
	input decode_pkg::reg_addr_t b, input decode_pkg::reg_addr_t w,
	input decode_pkg::word_t imm);
	id_word_t e;
	e = entry(decode_pkg::alu_add, decode_pkg::r1_im, a, b, w, imm);
	e.mem_read = load;
	e.mem_to_reg = load;
	e.mem_write = !load;
	e.src_sw = load ? decode_pkg::reg_none : b;
	return e;
endfunction

function automatic id_word_t rr_word(input decode_pkg::alu_op_e op,
	input decode_pkg::reg_addr_t a, input decode_pkg::reg_addr_t b,
	input decode_pkg::reg_addr_t w);
	id_word_t e;
	e = entry(op, decode_pkg::r1_r2, a, b, w, '0);
	e.src_b = b;
	return e;
endfunction

function automatic id_word_t model_decode(input decode_pkg::word_t w,
	input decode_pkg::word_t pc);
	decode_pkg::reg_addr_t rx;
	decode_pkg::reg_addr_t ry;
	decode_pkg::reg_addr_t rz;
	decode_pkg::reg_addr_t nr;
	decode_pkg::reg_addr_t sp;
	decode_pkg::word_t s8;
	decode_pkg::word_t s5;
	decode_pkg::word_t sh;
	id_word_t e;
	rx = {1'b0, w[10:8]};
	ry = {1'b0, w[7:5]};
	rz = {1'b0, w[4:2]};
	nr = decode_pkg::reg_none;
	sp = decode_pkg::reg_sp;
	s8 = {{8{w[7]}}, w[7:0]};
	s5 = {{11{w[4]}}, w[4:0]};
	sh = (w[4:2] == 3'd0) ? 16'd8 : {13'd0, w[4:2]};
	e = nop_word();
	case (w[15:11])
		decode_pkg::op_b:
			e = branch_word(decode_pkg::br_always, nr, {{5{w[10]}}, w[10:0]});
		decode_pkg::op_beqz: e = branch_word(decode_pkg::br_eqz, rx, s8);
		decode_pkg::op_bnez: e = branch_word(decode_pkg::br_nez, rx, s8);
		decode_pkg::op_shift: begin
			if (w[1:0] == decode_pkg::fn_sll)
				e = entry(decode_pkg::alu_sll, decode_pkg::r1_im, ry, nr, rx, sh);
			else if (w[1:0] == decode_pkg::fn_sra)
				e = entry(decode_pkg::alu_sra, decode_pkg::r1_im, ry, nr, rx, sh);
		end
		decode_pkg::op_addiu3:
			e = entry(decode_pkg::alu_add, decode_pkg::r1_im, rx, nr, ry, {{12{w[3]}}, w[3:0]});
		decode_pkg::op_addiu:
			e = entry(decode_pkg::alu_add, decode_pkg::r1_im, rx, nr, rx, s8);
		decode_pkg::op_group_sp: begin
			case (w[10:8])
				decode_pkg::sp_bteqz: e = branch_word(decode_pkg::br_eqz, decode_pkg::reg_t, s8);
				decode_pkg::sp_btnez: e = branch_word(decode_pkg::br_nez, decode_pkg::reg_t, s8);
				decode_pkg::sp_sw_rs: e = mem_word(1'b0, sp, decode_pkg::reg_ra, nr, s8);
				decode_pkg::sp_addsp:
					e = entry(decode_pkg::alu_add, decode_pkg::r1_im, sp, nr, sp, s8);
				decode_pkg::sp_mtsp:
					e = entry(decode_pkg::alu_move, decode_pkg::r1_nu, ry, nr, sp, '0);
				default: ;
			endcase
		end
		decode_pkg::op_li:
			e = entry(decode_pkg::alu_move, decode_pkg::im_nu, nr, nr, rx, {8'd0, w[7:0]});
		decode_pkg::op_cmpi:
			e = entry(decode_pkg::alu_equal, decode_pkg::r1_im, rx, nr, decode_pkg::reg_t, s8);
		decode_pkg::op_lw_sp: e = mem_word(1'b1, sp, nr, rx, s8);
		decode_pkg::op_lw: e = mem_word(1'b1, rx, nr, ry, s5);
		decode_pkg::op_sw_sp: e = mem_word(1'b0, sp, rx, nr, s8);
		decode_pkg::op_sw: e = mem_word(1'b0, rx, ry, nr, s5);
		decode_pkg::op_addsubu: begin
			if (w[1:0] == decode_pkg::fn_addu)
				e = rr_word(decode_pkg::alu_add, rx, ry, rz);
			else if (w[1:0] == decode_pkg::fn_subu)
				e = rr_word(decode_pkg::alu_sub, rx, ry, rz);
		end
		decode_pkg::op_group_rr: begin
			case (w[4:0])
				decode_pkg::rr_and: e = rr_word(decode_pkg::alu_and, rx, ry, rx);
				decode_pkg::rr_or: e = rr_word(decode_pkg::alu_or, rx, ry, rx);
				decode_pkg::rr_cmp: e = rr_word(decode_pkg::alu_equal, rx, ry, decode_pkg::reg_t);
				decode_pkg::rr_slt: e = rr_word(decode_pkg::alu_less, rx, ry, decode_pkg::reg_t);
				decode_pkg::rr_srav: e = rr_word(decode_pkg::alu_sra, ry, rx, ry); // Shift by rx
				decode_pkg::rr_pc: begin
					if (w[7:5] == decode_pkg::pc_jr) begin
						e = branch_word(decode_pkg::br_none, rx, '0);
						e.is_jump = 1'b1;
					end else if (w[7:5] == decode_pkg::pc_mfpc) begin
						e = entry(decode_pkg::alu_move, decode_pkg::im_nu, nr, nr, rx, pc);
					end
				end
				default: ;
			endcase
		end
		default: ; // Interrupt group and unused opcodes
	endcase
	return e;
endfunction

`endif

// File: test/tb_decoder_top.sv
`timescale 1ns/1ps

module tb_decoder_top;

	localparam int seed_value = 70;
	localparam int instr_count = 2000;
	localparam int reset_cycles = 5;
	localparam int timeout_cycles = 50;

	logic clk;
	logic rst;
	decode_pkg::word_t instruction;
	decode_pkg::word_t pc;
	decode_pkg::alu_op_e alu_op;
	decode_pkg::alu_src_e alu_src;
	decode_pkg::branch_cond_e branch_cond;
	logic is_jump;
	logic mem_read;
	logic mem_write;
	logic reg_write;
	logic mem_to_reg;
	decode_pkg::reg_addr_t reg_a;
	decode_pkg::reg_addr_t reg_b;
	decode_pkg::reg_addr_t src_a;
	decode_pkg::reg_addr_t src_b;
	decode_pkg::reg_addr_t src_sw;
	decode_pkg::reg_addr_t w_reg;
	decode_pkg::word_t immediate;

	`include "decode_model.svh"

	integer seed;
	id_word_t expected_q[$];
	decode_pkg::word_t pattern_value[$]; // Fixed bits of each kept encoding
	decode_pkg::word_t pattern_mask[$];

	decoder_top uut (.*);

	always #5 clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// Checking
	////////////////////////////////////////////////////////////////////////////

	task automatic compare_field(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0d ns: %s expected %h actual %h", $time, name,
				expected, actual);
			$display("CHECKS FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_outputs(input id_word_t exp);
		compare_field("alu_op", exp.alu_op, alu_op);
		compare_field("alu_src", exp.alu_src, alu_src);
		compare_field("branch_cond", exp.branch_cond, branch_cond);
		compare_field("is_jump", exp.is_jump, is_jump);
		compare_field("mem_read", exp.mem_read, mem_read);
		compare_field("mem_write", exp.mem_write, mem_write);
		compare_field("reg_write", exp.reg_write, reg_write);
		compare_field("mem_to_reg", exp.mem_to_reg, mem_to_reg);
		compare_field("reg_a", exp.reg_a, reg_a);
		compare_field("reg_b", exp.reg_b, reg_b);
		compare_field("src_a", exp.src_a, src_a);
		compare_field("src_b", exp.src_b, src_b);
		compare_field("src_sw", exp.src_sw, src_sw);
		compare_field("w_reg", exp.w_reg, w_reg);
		compare_field("immediate", exp.immediate, immediate);
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out waiting for %s", what);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	// Bound assertions count their failures
	always @(negedge clk) begin
		if (uut.u_assert.failures != 0) begin
			$display("A bound assertion on the decoder outputs failed");
			$display("CHECKS FAILED");
			$fatal(1);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	task automatic add_pattern(input decode_pkg::word_t value, input decode_pkg::word_t mask);
		pattern_value.push_back(value);
		pattern_mask.push_back(mask);
	endtask

	task automatic fill_patterns();
		add_pattern({decode_pkg::op_nop, 11'd0}, 16'hf800);
		add_pattern({decode_pkg::op_b, 11'd0}, 16'hf800);
		add_pattern({decode_pkg::op_beqz, 11'd0}, 16'hf800);
		add_pattern({decode_pkg::op_bnez, 11'd0}, 16'hf800);
		add_pattern({decode_pkg::op_addiu3, 11'd0}, 16'hf800);
		add_pattern({decode_pkg::op_addiu, 11'd0}, 16'hf800);
		add_pattern({decode_pkg::op_li, 11'd0}, 16'hf800);
		add_pattern({decode_pkg::op_cmpi, 11'd0}, 16'hf800);
		add_pattern({decode_pkg::op_lw_sp, 11'd0}, 16'hf800);
		add_pattern({decode_pkg::op_lw, 11'd0}, 16'hf800);
		add_pattern({decode_pkg::op_sw_sp, 11'd0}, 16'hf800);
		add_pattern({decode_pkg::op_sw, 11'd0}, 16'hf800);
		add_pattern({decode_pkg::op_shift, 9'd0, decode_pkg::fn_sll}, 16'hf803);
		add_pattern({decode_pkg::op_shift, 9'd0, decode_pkg::fn_sra}, 16'hf803);
		add_pattern({decode_pkg::op_addsubu, 9'd0, decode_pkg::fn_addu}, 16'hf803);
		add_pattern({decode_pkg::op_addsubu, 9'd0, decode_pkg::fn_subu}, 16'hf803);
		add_pattern({decode_pkg::op_group_sp, decode_pkg::sp_bteqz, 8'd0}, 16'hff00);
		add_pattern({decode_pkg::op_group_sp, decode_pkg::sp_btnez, 8'd0}, 16'hff00);
		add_pattern({decode_pkg::op_group_sp, decode_pkg::sp_sw_rs, 8'd0}, 16'hff00);
		add_pattern({decode_pkg::op_group_sp, decode_pkg::sp_addsp, 8'd0}, 16'hff00);
		add_pattern({decode_pkg::op_group_sp, decode_pkg::sp_mtsp, 8'd0}, 16'hff00);
		add_pattern({decode_pkg::op_group_rr, 6'd0, decode_pkg::rr_and}, 16'hf81f);
		add_pattern({decode_pkg::op_group_rr, 6'd0, decode_pkg::rr_or}, 16'hf81f);
		add_pattern({decode_pkg::op_group_rr, 6'd0, decode_pkg::rr_cmp}, 16'hf81f);
		add_pattern({decode_pkg::op_group_rr, 6'd0, decode_pkg::rr_slt}, 16'hf81f);
		add_pattern({decode_pkg::op_group_rr, 6'd0, decode_pkg::rr_srav}, 16'hf81f);
		add_pattern({decode_pkg::op_group_rr, 3'd0, decode_pkg::pc_jr, decode_pkg::rr_pc},
			16'hf8ff);
		add_pattern({decode_pkg::op_group_rr, 3'd0, decode_pkg::pc_mfpc, decode_pkg::rr_pc},
			16'hf8ff);
	endtask

	// Three in four words hit a kept encoding
	task automatic next_instruction(output decode_pkg::word_t w);
		decode_pkg::word_t r;
		int idx;
		r = decode_pkg::word_t'($random(seed));
		if (($random(seed) & 3) != 0) begin
			idx = $unsigned($random(seed)) % pattern_value.size();
			w = (r & ~pattern_mask[idx]) | pattern_value[idx];
		end else begin
			w = r;
		end
	endtask

	task automatic drive_next();
		decode_pkg::word_t w;
		decode_pkg::word_t p;
		next_instruction(w);
		p = decode_pkg::word_t'($random(seed));
		instruction <= w;
		pc <= p;
		expected_q.push_back(model_decode(w, p));
	endtask

	initial begin
		int cycles;
		clk = 1'b0;
		rst = 1'b1;
		instruction = '0;
		pc = '0;
		seed = seed_value;
		fill_patterns();

		// Inputs are ignored while reset is held
		repeat (reset_cycles - 1) begin
			@(posedge clk);
			instruction <= decode_pkg::word_t'($random(seed));
			pc <= decode_pkg::word_t'($random(seed));
			@(negedge clk);
			check_outputs(nop_word());
		end

		@(posedge clk);
		rst <= 1'b0;
		drive_next();
		cycles = 0;
		while (rst !== 1'b0) begin
			@(negedge clk);
			cycles++;
			if (cycles > timeout_cycles)
				report_timeout("reset release");
		end
		check_outputs(nop_word()); // Edge that saw reset last

		for (int i = 1; i < instr_count; i++) begin
			@(posedge clk);
			drive_next();
			@(negedge clk);
			check_outputs(expected_q.pop_front());
		end

		cycles = 0;
		while (expected_q.size() > 0) begin
			@(negedge clk);
			check_outputs(expected_q.pop_front());
			cycles++;
			if (cycles > timeout_cycles)
				report_timeout("the last decoded word");
		end

		@(negedge clk);
		if (uut.u_assert.failures != 0) begin
			$display("Bound assertions failed %0d times", uut.u_assert.failures);
			$display("CHECKS FAILED");
			$fatal(1);
		end else begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
	end

endmodule

// File: filelist.f
+incdir+test
source/decode_pkg.sv
source/ctrl_if.sv
source/operand_if.sv
source/instr_classify.sv
source/control_gen.sv
source/operand_gen.sv
source/id_register.sv
source/decoder_top.sv
test/decoder_assertions.sv
test/tb_decoder_top.sv

// File: Bender.yml
package:
  name: id_decode

sources:
  - source/decode_pkg.sv
  - source/ctrl_if.sv
  - source/operand_if.sv
  - source/instr_classify.sv
  - source/control_gen.sv
  - source/operand_gen.sv
  - source/id_register.sv
  - source/decoder_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/decoder_assertions.sv
      - test/tb_decoder_top.sv
